/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module tb_line_loader -Mdir obj_dir -o sim_line_loader

run: compile
	./obj_dir/sim_line_loader > sim.log 2>&1; cat sim.log
	@if grep -q "Simulation failed" sim.log; then echo "FAIL"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" sim.log; then echo "FAIL"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf obj_dir sim.log

/* compile.f */
load_pkg.sv
load_cfg_if.sv
load_regs.sv
load_requester.sv
line_fifo.sv
load_receiver.sv
line_store.sv
line_loader_top.sv
line_loader_assert.sv
tb_line_loader.sv

/* line_fifo.sv */
`timescale 1ns/10ps

module line_fifo
#(
    parameter type payload_t = logic [31:0],
    parameter int LOG2_DEPTH = 3
)
(
    input  logic clk,
    input  logic reset,
    input  logic we,
    input  payload_t wdata,
    input  logic re,
    output payload_t rdata,
    output logic rvalid,
    output logic empty,
    output logic [LOG2_DEPTH:0] count,
    output logic almost_full
);

    payload_t mem [1 << LOG2_DEPTH];
    logic [LOG2_DEPTH-1:0] wr_ptr;
    logic [LOG2_DEPTH-1:0] rd_ptr;
    logic do_write;
    logic do_read;

    assign empty = (count == '0);
    // Two slots of headroom for writes already on their way
    assign almost_full = count >= (LOG2_DEPTH+1)'((1 << LOG2_DEPTH) - 2);

    assign do_read = re && !empty;
    assign do_write = we && (count < (LOG2_DEPTH+1)'(1 << LOG2_DEPTH));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= do_read;
            if (do_write)
            begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_read)
            begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + do_write - do_read;
        end
    end

    // Storage and registered read
    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= wdata;
        end
        if (do_read)
        begin
            rdata <= mem[rd_ptr];
        end
    end

endmodule

/* line_loader_assert.sv */
`timescale 1ns/10ps

module line_loader_assert
    import load_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic rd_req_almost_full,
    input  count_t requested,
    input  count_t responded,
    input  logic rd_req_valid,
    input  addr_t rd_req_addr,
    input  burst_len_t rd_req_len
);

    // A request on the port comes from a cycle with almost full low
    no_issue_when_full: assert property (@(posedge clk) disable iff (reset)
        rd_req_valid |-> !$past(rd_req_almost_full))
        else $error("read request issued while almost full");

    // Outstanding lines fit in the prefetch FIFO
    in_flight_bound: assert property (@(posedge clk) disable iff (reset)
        (requested - responded) <= count_t'(PREFETCH_DEPTH))
        else $error("lines in flight exceed the prefetch depth");

    burst4_aligned: assert property (@(posedge clk) disable iff (reset)
        (rd_req_valid && rd_req_len == BURST_4) |-> (rd_req_addr[1:0] == 2'b00))
        else $error("four-line burst from an unaligned address");

    burst2_aligned: assert property (@(posedge clk) disable iff (reset)
        (rd_req_valid && rd_req_len == BURST_2) |-> (rd_req_addr[0] == 1'b0))
        else $error("two-line burst from an odd address");

endmodule

bind load_requester line_loader_assert u_assert
(
    .clk(clk),
    .reset(reset),
    .rd_req_almost_full(rd_req_almost_full),
    .requested(requested),
    .responded(responded),
    .rd_req_valid(rd_req_valid),
    .rd_req_addr(rd_req_addr),
    .rd_req_len(rd_req_len)
);

/* line_loader_top.sv */
`timescale 1ns/10ps

module line_loader_top
    import load_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    output logic op_done,
    input  addr_t cfg_base_addr,
    input  addr_t cfg_offset,
    input  count_t cfg_length,
    input  logic cfg_multiline,
    input  logic cfg_synthetic,
    input  logic [STORE_LOG2_DEPTH-1:0] cfg_store_base,
    output logic rd_req_valid,
    output addr_t rd_req_addr,
    output burst_len_t rd_req_len,
    output logic [7:0] rd_req_tag,
    input  logic rd_req_almost_full,
    input  logic rd_rsp_valid,
    input  line_t rd_rsp_data,
    input  logic out_pop,
    output logic out_valid,
    output line_t out_data,
    output count_t out_index,
    input  logic [STORE_LOG2_DEPTH-1:0] store_raddr,
    output line_t store_rdata
);

    load_cfg_if cfg_bus();

    // Prefetch FIFO
    logic pf_we;
    line_t pf_wdata;
    logic pf_re;
    line_t pf_rdata;
    logic pf_rvalid;
    logic pf_empty;
    logic [LOG2_PREFETCH_DEPTH:0] pf_count;

    // Stream FIFO and store write side
    logic stream_we;
    stream_beat_t stream_wdata;
    stream_beat_t stream_rdata;
    logic stream_almost_full;
    logic store_we;
    logic [STORE_LOG2_DEPTH-1:0] store_waddr;
    line_t store_wdata;

    // ******************************
    // Configuration and requests
    // ******************************
    load_regs u_regs
    (
        .clk,
        .reset,
        .op_start,
        .cfg_base_addr,
        .cfg_offset,
        .cfg_length,
        .cfg_multiline,
        .cfg_synthetic,
        .cfg_store_base,
        .cfg(cfg_bus.regs)
    );

    load_requester u_requester
    (
        .clk,
        .reset,
        .cfg(cfg_bus.user),
        .prefetch_count(pf_count),
        .rd_rsp_valid,
        .rd_req_almost_full,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_len,
        .rd_req_tag
    );

    // ******************************
    // Receive path
    // ******************************
    line_fifo #(.payload_t(line_t), .LOG2_DEPTH(LOG2_PREFETCH_DEPTH)) u_prefetch
    (
        .clk,
        .reset,
        .we(pf_we),
        .wdata(pf_wdata),
        .re(pf_re),
        .rdata(pf_rdata),
        .rvalid(pf_rvalid),
        .empty(pf_empty),
        .count(pf_count),
        .almost_full()
    );

    load_receiver u_receiver
    (
        .clk,
        .reset,
        .cfg(cfg_bus.user),
        .rd_rsp_valid,
        .rd_rsp_data,
        .pf_we,
        .pf_wdata,
        .pf_empty,
        .pf_rdata,
        .pf_rvalid,
        .pf_re,
        .stream_almost_full,
        .stream_we,
        .stream_wdata,
        .store_we,
        .store_waddr,
        .store_wdata,
        .op_done
    );

    // out_valid marks the beat popped by out_pop one cycle earlier
    line_fifo #(.payload_t(stream_beat_t), .LOG2_DEPTH(LOG2_STREAM_DEPTH)) u_stream
    (
        .clk,
        .reset,
        .we(stream_we),
        .wdata(stream_wdata),
        .re(out_pop),
        .rdata(stream_rdata),
        .rvalid(out_valid),
        .empty(),
        .count(),
        .almost_full(stream_almost_full)
    );

    assign out_data = stream_rdata.data;
    assign out_index = stream_rdata.index;

    line_store u_store
    (
        .clk,
        .we(store_we),
        .waddr(store_waddr),
        .wdata(store_wdata),
        .raddr(store_raddr),
        .rdata(store_rdata)
    );

endmodule

/* line_store.sv */
`timescale 1ns/10ps

module line_store
    import load_pkg::*;
(
    input  logic clk,
    input  logic we,
    input  logic [STORE_LOG2_DEPTH-1:0] waddr,
    input  line_t wdata,
    input  logic [STORE_LOG2_DEPTH-1:0] raddr,
    output line_t rdata
);

    line_t mem [1 << STORE_LOG2_DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr] <= wdata;
        end
        // Read data one cycle after the address
        rdata <= mem[raddr];
    end

endmodule

/* load_cfg_if.sv */
`timescale 1ns/10ps

interface load_cfg_if
    import load_pkg::*;
();

    addr_t start_addr;
    count_t length;
    logic multiline;
    logic synthetic;
    logic [STORE_LOG2_DEPTH-1:0] store_base;

    // One-cycle pulse that opens a load
    logic start;

    modport regs
    (
        output start_addr,
        output length,
        output multiline,
        output synthetic,
        output store_base,
        output start
    );

    modport user
    (
        input start_addr,
        input length,
        input multiline,
        input synthetic,
        input store_base,
        input start
    );

endinterface

/* load_pkg.sv */
package load_pkg;

    // ******************************
    // Widths and depths
    // ******************************
    localparam int ADDR_WIDTH = 16;
    localparam int LINE_WIDTH = 32;
    localparam int COUNT_WIDTH = 16;

    localparam int LOG2_PREFETCH_DEPTH = 3;
    localparam int PREFETCH_DEPTH = 1 << LOG2_PREFETCH_DEPTH;
    localparam int LOG2_STREAM_DEPTH = 3;
    localparam int STORE_LOG2_DEPTH = 6;

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [LINE_WIDTH-1:0] line_t;
    typedef logic [COUNT_WIDTH-1:0] count_t;

    // Burst codes as the read port encodes them
    typedef enum logic [1:0]
    {
        BURST_1 = 2'd0,
        BURST_2 = 2'd1,
        BURST_4 = 2'd3
    } burst_len_t;

    // One beat of the output stream
    typedef struct packed
    {
        line_t  data;
        count_t index;
    } stream_beat_t;

    function automatic count_t burst_lines(burst_len_t code);
        case (code)
            BURST_2: return count_t'(2);
            BURST_4: return count_t'(4);
            default: return count_t'(1);
        endcase
    endfunction

endpackage

/* load_receiver.sv */
`timescale 1ns/10ps

module load_receiver
    import load_pkg::*;
(
    input  logic clk,
    input  logic reset,
    load_cfg_if.user cfg,
    input  logic rd_rsp_valid,
    input  line_t rd_rsp_data,
    output logic pf_we,
    output line_t pf_wdata,
    input  logic pf_empty,
    input  line_t pf_rdata,
    input  logic pf_rvalid,
    output logic pf_re,
    input  logic stream_almost_full,
    output logic stream_we,
    output stream_beat_t stream_wdata,
    output logic store_we,
    output logic [STORE_LOG2_DEPTH-1:0] store_waddr,
    output line_t store_wdata,
    output logic op_done
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_READ,
        S_DONE
    } rcv_state_t;

    rcv_state_t state;
    count_t rsp_index;
    count_t recv_count;

    // Pop only while the stream can take the lines already in the pipe
    assign pf_re = (state == S_READ) && !pf_empty && !stream_almost_full;

    // ******************************
    // Control and strobes
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            pf_we <= 1'b0;
            stream_we <= 1'b0;
            store_we <= 1'b0;
            op_done <= 1'b0;
            rsp_index <= '0;
            recv_count <= '0;
        end
        else
        begin
            pf_we <= rd_rsp_valid && (state == S_READ);
            stream_we <= pf_rvalid;
            store_we <= pf_rvalid;
            op_done <= 1'b0;
            if (rd_rsp_valid && state == S_READ)
            begin
                rsp_index <= rsp_index + 1'b1;
            end
            if (pf_rvalid)
            begin
                recv_count <= recv_count + 1'b1;
            end

            case (state)
                S_IDLE:
                begin
                    if (cfg.start)
                    begin
                        rsp_index <= '0;
                        recv_count <= '0;
                        // Empty load ends right away
                        if (cfg.length == '0)
                        begin
                            op_done <= 1'b1;
                        end
                        else
                        begin
                            state <= S_READ;
                        end
                    end
                end
                S_READ:
                begin
                    if (pf_rvalid && recv_count == cfg.length - 1'b1)
                    begin
                        state <= S_DONE;
                    end
                end
                S_DONE:
                begin
                    op_done <= 1'b1;
                    state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // ******************************
    // Data paths
    // ******************************
    always_ff @(posedge clk)
    begin
        if (cfg.synthetic)
        begin
            pf_wdata <= line_t'(rsp_index);
        end
        else
        begin
            pf_wdata <= rd_rsp_data;
        end
        stream_wdata.data <= pf_rdata;
        stream_wdata.index <= recv_count;
        store_wdata <= pf_rdata;
        store_waddr <= cfg.store_base + recv_count[STORE_LOG2_DEPTH-1:0];
    end

endmodule

/* load_regs.sv */
`timescale 1ns/10ps

module load_regs
    import load_pkg::*;
(
    input  logic clk,
    input  logic reset,
    input  logic op_start,
    input  addr_t cfg_base_addr,
    input  addr_t cfg_offset,
    input  count_t cfg_length,
    input  logic cfg_multiline,
    input  logic cfg_synthetic,
    input  logic [STORE_LOG2_DEPTH-1:0] cfg_store_base,
    load_cfg_if.regs cfg
);

    // Start follows op_start by one cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            cfg.start <= 1'b0;
        end
        else
        begin
            cfg.start <= op_start;
        end
    end

    // Settings held until the next op_start
    always_ff @(posedge clk)
    begin
        if (op_start)
        begin
            cfg.start_addr <= cfg_base_addr + cfg_offset;
            cfg.length <= cfg_length;
            cfg.multiline <= cfg_multiline;
            cfg.synthetic <= cfg_synthetic;
            cfg.store_base <= cfg_store_base;
        end
    end

endmodule

/* load_requester.sv */
`timescale 1ns/10ps

module load_requester
    import load_pkg::*;
(
    input  logic clk,
    input  logic reset,
    load_cfg_if.user cfg,
    input  logic [LOG2_PREFETCH_DEPTH:0] prefetch_count,
    input  logic rd_rsp_valid,
    input  logic rd_req_almost_full,
    output logic rd_req_valid,
    output addr_t rd_req_addr,
    output burst_len_t rd_req_len,
    output logic [7:0] rd_req_tag
);

    typedef enum logic [1:0]
    {
        S_IDLE,
        S_READ,
        S_DONE
    } req_state_t;

    req_state_t state;
    addr_t run_addr;
    count_t requested;
    count_t responded;
    logic rsp_seen;

    logic active;
    addr_t cur_addr;
    count_t cur_req;
    count_t in_flight;
    count_t reserved;
    logic [COUNT_WIDTH:0] req_plus2;
    logic [COUNT_WIDTH:0] req_plus4;
    logic [COUNT_WIDTH:0] credit_need;
    logic want;
    burst_len_t burst;
    count_t burst_cnt;
    logic credit_ok;
    logic issue;

    // ******************************
    // Burst choice and credit check
    // ******************************

    // The start cycle already issues from the fresh start address
    assign active = (state == S_READ) || (state == S_IDLE && cfg.start);
    assign cur_addr = (state == S_IDLE) ? cfg.start_addr : run_addr;
    assign cur_req = (state == S_IDLE) ? '0 : requested;
    assign in_flight = (state == S_IDLE) ? '0 : requested - responded;

    assign req_plus2 = {1'b0, cur_req} + (COUNT_WIDTH+1)'(2);
    assign req_plus4 = {1'b0, cur_req} + (COUNT_WIDTH+1)'(4);

    always_comb
    begin
        want = 1'b1;
        burst = BURST_1;
        if (cfg.multiline && cur_addr[1:0] == 2'b00 && req_plus4 <= {1'b0, cfg.length})
        begin
            burst = BURST_4;
        end
        else if (cfg.multiline && cur_addr[0] == 1'b0 && req_plus2 <= {1'b0, cfg.length})
        begin
            burst = BURST_2;
        end
        else if (cur_req >= cfg.length)
        begin
            want = 1'b0;
        end
    end

    assign burst_cnt = burst_lines(burst);

    // Lines already owed to the prefetch FIFO plus the new burst
    assign reserved = in_flight + count_t'(prefetch_count);
    assign credit_need = {1'b0, reserved} + {1'b0, burst_cnt};
    assign credit_ok = credit_need <= (COUNT_WIDTH+1)'(PREFETCH_DEPTH);

    assign issue = active && want && credit_ok && !rd_req_almost_full;

    // ******************************
    // State and counters
    // ******************************
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= S_IDLE;
            rd_req_valid <= 1'b0;
            rsp_seen <= 1'b0;
            requested <= '0;
            responded <= '0;
        end
        else
        begin
            rd_req_valid <= issue;
            // Delayed by one so a line counts here when the FIFO counts it
            rsp_seen <= rd_rsp_valid;
            if (rsp_seen)
            begin
                responded <= responded + 1'b1;
            end
            if (issue)
            begin
                requested <= cur_req + burst_cnt;
            end
            else if (state == S_IDLE && cfg.start)
            begin
                requested <= '0;
            end

            case (state)
                S_IDLE:
                begin
                    if (cfg.start)
                    begin
                        responded <= '0;
                        state <= S_READ;
                    end
                end
                S_READ:
                begin
                    if (requested == cfg.length)
                    begin
                        state <= S_DONE;
                    end
                end
                S_DONE:
                begin
                    state <= S_IDLE;
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // Request fields and running address
    always_ff @(posedge clk)
    begin
        if (issue)
        begin
            run_addr <= cur_addr + addr_t'(burst_cnt);
            rd_req_addr <= cur_addr;
            rd_req_len <= burst;
            rd_req_tag <= cur_req[7:0];
        end
        else if (state == S_IDLE && cfg.start)
        begin
            run_addr <= cfg.start_addr;
        end
    end

endmodule

/* tb_line_loader.sv */
`timescale 1ns/10ps

module tb_line_loader
    import load_pkg::*;
();

    // Lines moved over all directed tests
    localparam int TEST_LINES = 5 + 11 + 7 + 8 + 20;
    // Up to 70 cycles per line with stalls and readback, plus the back-pressure hold
    localparam int TIMEOUT_CYCLES = 400 + TEST_LINES * 70;

    logic clk = 1'b0;
    logic reset;
    logic op_start;
    logic op_done;
    addr_t cfg_base_addr;
    addr_t cfg_offset;
    count_t cfg_length;
    logic cfg_multiline;
    logic cfg_synthetic;
    logic [STORE_LOG2_DEPTH-1:0] cfg_store_base;
    logic rd_req_valid;
    addr_t rd_req_addr;
    burst_len_t rd_req_len;
    logic [7:0] rd_req_tag;
    logic rd_req_almost_full = 1'b0;
    logic rd_rsp_valid = 1'b0;
    line_t rd_rsp_data = '0;
    logic out_pop;
    logic out_valid;
    line_t out_data;
    count_t out_index;
    logic [STORE_LOG2_DEPTH-1:0] store_raddr;
    line_t store_rdata;

    int cycle = 0;
    int check_count = 0;
    int error_count = 0;
    int done_count = 0;
    int req_count = 0;

    // Expected request sequence of the running load
    addr_t exp_addr;
    int exp_req;
    int cur_length;
    logic cur_multi;
    // Lines the DUT asked for in the running load
    int req_lines = 0;

    // Memory model response queue
    addr_t pend_addr[$];
    int pend_ready[$];
    int last_ready = 0;

    // Collected stream beats
    line_t beat_data_q[$];
    count_t beat_index_q[$];

    line_loader_top i_dut
    (
        .clk,
        .reset,
        .op_start,
        .op_done,
        .cfg_base_addr,
        .cfg_offset,
        .cfg_length,
        .cfg_multiline,
        .cfg_synthetic,
        .cfg_store_base,
        .rd_req_valid,
        .rd_req_addr,
        .rd_req_len,
        .rd_req_tag,
        .rd_req_almost_full,
        .rd_rsp_valid,
        .rd_rsp_data,
        .out_pop,
        .out_valid,
        .out_data,
        .out_index,
        .store_raddr,
        .store_rdata
    );

    always #20 clk = ~clk;

    // ******************************
    // Checks and expected values
    // ******************************
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    function automatic line_t memory_word(input addr_t addr);
        return {16'h0000, addr} ^ 32'h5A5A0000;
    endfunction

    function automatic line_t expected_line(input addr_t start, input int index,
                                            input logic synthetic);
        if (synthetic)
        begin
            return line_t'(index);
        end
        return memory_word(start + addr_t'(index));
    endfunction

    // Largest aligned burst that still fits in the load
    function automatic int expected_burst(input addr_t addr, input int requested,
                                          input int length, input logic multiline);
        if (multiline && addr[1:0] == 2'b00 && requested + 4 <= length)
        begin
            return 4;
        end
        if (multiline && addr[0] == 1'b0 && requested + 2 <= length)
        begin
            return 2;
        end
        return 1;
    endfunction

    // ******************************
    // Memory model and monitors
    // ******************************
    always @(negedge clk)
    begin : memory_model
        int exp_n;
        int ready;
        if (!reset)
        begin
            if (rd_req_valid)
            begin
                exp_n = expected_burst(exp_addr, exp_req, cur_length, cur_multi);
                if (exp_req >= cur_length)
                begin
                    report_failure("read request after all lines were requested");
                end
                check_value("rd_req_addr", rd_req_addr, exp_addr);
                check_value("rd_req_len lines", burst_lines(rd_req_len), exp_n);
                check_value("rd_req_tag", rd_req_tag, exp_req[7:0]);
                // Bursts answer in order after 1 to 6 cycles
                ready = cycle + 1 + int'($urandom % 6);
                if (ready < last_ready)
                begin
                    ready = last_ready;
                end
                last_ready = ready;
                for (int j = 0; j < int'(burst_lines(rd_req_len)); j++)
                begin
                    pend_addr.push_back(rd_req_addr + addr_t'(j));
                    pend_ready.push_back(ready);
                end
                exp_addr = exp_addr + addr_t'(exp_n);
                exp_req = exp_req + exp_n;
                req_lines = req_lines + int'(burst_lines(rd_req_len));
                req_count++;
            end
            if (pend_addr.size() > 0 && pend_ready[0] <= cycle)
            begin
                rd_rsp_valid = 1'b1;
                rd_rsp_data = memory_word(pend_addr.pop_front());
                void'(pend_ready.pop_front());
            end
            else
            begin
                rd_rsp_valid = 1'b0;
            end
            rd_req_almost_full = ($urandom % 8) == 0;
        end
    end

    always @(negedge clk)
    begin
        if (out_valid)
        begin
            beat_data_q.push_back(out_data);
            beat_index_q.push_back(out_index);
        end
        if (op_done)
        begin
            done_count++;
        end
    end

    // Run limit
    always @(posedge clk)
    begin
        cycle = cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("timeout: no end of the tests after %0d cycles", cycle);
            $display("checks: %0d, errors: %0d", check_count, error_count);
            $display("Simulation failed");
            $finish;
        end
    end

    // ******************************
    // Test tasks
    // ******************************
    task automatic check_results(input addr_t start, input int length, input logic synthetic,
                                 input int store_base);
        int waited;
        int addr;
        waited = 0;
        while (beat_data_q.size() < length && waited < 40)
        begin
            @(negedge clk);
            waited++;
        end
        if (beat_data_q.size() != length)
        begin
            report_failure($sformatf("stream delivered %0d beats instead of %0d",
                                     beat_data_q.size(), length));
        end
        for (int i = 0; i < length && i < beat_data_q.size(); i++)
        begin
            check_value("out_index", beat_index_q[i], i);
            check_value("out_data", beat_data_q[i], expected_line(start, i, synthetic));
        end
        // Store read is registered, data one cycle after the address
        for (int i = 0; i < length; i++)
        begin
            addr = (store_base + i) % (1 << STORE_LOG2_DEPTH);
            @(negedge clk);
            store_raddr = addr[STORE_LOG2_DEPTH-1:0];
            @(negedge clk);
            check_value($sformatf("store_rdata[%0d]", addr), store_rdata,
                        expected_line(start, i, synthetic));
        end
    endtask

    task automatic run_load(input addr_t base, input addr_t offset, input int length,
                            input logic multiline, input logic synthetic,
                            input int store_base, input int hold_cycles);
        int done_before;
        @(negedge clk);
        cfg_base_addr = base;
        cfg_offset = offset;
        cfg_length = count_t'(length);
        cfg_multiline = multiline;
        cfg_synthetic = synthetic;
        cfg_store_base = store_base[STORE_LOG2_DEPTH-1:0];
        exp_addr = base + offset;
        exp_req = 0;
        req_lines = 0;
        cur_length = length;
        cur_multi = multiline;
        beat_data_q.delete();
        beat_index_q.delete();
        done_before = done_count;
        out_pop = (hold_cycles == 0);
        op_start = 1'b1;
        @(negedge clk);
        op_start = 1'b0;
        if (hold_cycles > 0)
        begin
            repeat (hold_cycles) @(negedge clk);
            out_pop = 1'b1;
        end
        while (done_count == done_before)
        begin
            @(negedge clk);
        end
        check_value("requested lines", req_lines, length);
        check_results(base + offset, length, synthetic, store_base);
    endtask

    task automatic single_line_load();
        run_load(16'h0100, 16'h0000, 5, 1'b0, 1'b0, 4, 0);
    endtask

    task automatic aligned_multiline_load();
        run_load(16'h0200, 16'h0004, 11, 1'b1, 1'b0, 10, 0);
    endtask

    task automatic unaligned_multiline_load();
        run_load(16'h0003, 16'h0002, 7, 1'b1, 1'b0, 20, 0);
    endtask

    task automatic synthetic_load();
        run_load(16'h0031, 16'h0010, 8, 1'b1, 1'b1, 40, 0);
    endtask

    task automatic zero_length_load();
        int req_before;
        @(negedge clk);
        cfg_length = '0;
        cfg_multiline = 1'b1;
        cfg_synthetic = 1'b0;
        exp_req = 0;
        cur_length = 0;
        req_before = req_count;
        op_start = 1'b1;
        @(negedge clk);
        op_start = 1'b0;
        check_value("op_done", op_done, 1'b0);
        @(negedge clk);
        check_value("op_done", op_done, 1'b1);
        @(negedge clk);
        check_value("op_done", op_done, 1'b0);
        repeat (10) @(negedge clk);
        check_value("request count", req_count - req_before, 0);
    endtask

    task automatic back_pressure_load();
        run_load(16'h1000, 16'h0000, 20, 1'b1, 1'b0, 50, 120);
    endtask

    initial
    begin
        void'($urandom(38222));
        reset = 1'b1;
        op_start = 1'b0;
        cfg_base_addr = '0;
        cfg_offset = '0;
        cfg_length = '0;
        cfg_multiline = 1'b0;
        cfg_synthetic = 1'b0;
        cfg_store_base = '0;
        out_pop = 1'b1;
        store_raddr = '0;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        single_line_load();
        aligned_multiline_load();
        unaligned_multiline_load();
        synthetic_load();
        zero_length_load();
        back_pressure_load();

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("Simulation completed successfully");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
